/* logic/aluPkg.sv */
`default_nettype none

package aluPkg;

    // ---------------------------------------------------------------------
    // Widths
    // ---------------------------------------------------------------------

    // Register data path
    localparam int dataWidth = 32;
    // Five bits address the 32 general registers
    localparam int regIndexWidth = 5;
    // A leading count runs 0 to 32, so it needs six bits
    localparam int countWidth = 6;
    // I-type immediate field
    localparam int immediateWidth = 16;

    // ---------------------------------------------------------------------
    // Opcode and function field encodings
    // ---------------------------------------------------------------------

    // Primary opcodes
    localparam logic [5:0] opcodeSpecial = 6'b000000;
    localparam logic [5:0] opcodeSpecial2 = 6'b011100;
    localparam logic [5:0] opcodeAddi = 6'b001000;
    localparam logic [5:0] opcodeAddiu = 6'b001001;

    // Function codes under SPECIAL
    localparam logic [5:0] functAdd = 6'b100000;
    localparam logic [5:0] functAddu = 6'b100001;
    localparam logic [5:0] functSub = 6'b100010;
    localparam logic [5:0] functSubu = 6'b100011;

    // Function codes under SPECIAL2
    localparam logic [5:0] functClz = 6'b100000;
    localparam logic [5:0] functClo = 6'b100001;

    // ---------------------------------------------------------------------
    // Shared types
    // ---------------------------------------------------------------------

    typedef logic [dataWidth-1:0] dataWord;
    typedef logic [regIndexWidth-1:0] regIndex;

    // Register form: opcode, a, b, c, shift amount, function
    typedef struct packed {
        logic [5:0] opcode;
        regIndex a;
        regIndex b;
        regIndex c;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeFields;

    // Immediate form: opcode, a, b, 16-bit immediate
    typedef struct packed {
        logic [5:0] opcode;
        regIndex a;
        regIndex b;
        logic [immediateWidth-1:0] immediate;
    } iTypeFields;

    // The same instruction word, viewed as either format
    typedef union packed {
        rTypeFields r;
        iTypeFields i;
    } instrWord;

    typedef enum logic [2:0] {
        opNone,
        opAdd,
        opSub,
        opClo,
        opClz
    } aluOp;

    // Decoder output, shared by both units and the write-back stage
    typedef struct packed {
        aluOp op;
        logic useImmediate;
        logic trapOnOverflow;
        regIndex destination;
        dataWord immediate;
    } decodedOp;

    // Registered result record
    typedef struct packed {
        logic writeEnable;
        regIndex destination;
        dataWord data;
        logic overflow;
        logic zero;
    } writeBack;

endpackage

`default_nettype wire

/* logic/instructionDecoder.sv */
`default_nettype none

module instructionDecoder
    import aluPkg::*;
(
    input instrWord instruction,
    output decodedOp decoded
);

    // ---------------------------------------------------------------------
    // Field extraction
    // ---------------------------------------------------------------------

    // Every kept R form needs the shift amount clear
    logic shamtZero;
    dataWord signExtended;

    assign shamtZero = (instruction.r.shamt == 5'd0);

    // Immediate is always sign-extended, even for ADDIU
    assign signExtended = {
        {(dataWidth - immediateWidth){instruction.i.immediate[immediateWidth-1]}},
        instruction.i.immediate
    };

    // ---------------------------------------------------------------------
    // Operation decode
    // ---------------------------------------------------------------------

    always_comb begin
        // Anything unmatched falls through as no operation
        decoded = '0;
        decoded.op = opNone;
        decoded.immediate = signExtended;

        case (instruction.r.opcode)
            opcodeSpecial: begin
                // R forms write register c
                decoded.destination = instruction.r.c;
                if (shamtZero) begin
                    case (instruction.r.funct)
                        functAdd: begin
                            decoded.op = opAdd;
                            decoded.trapOnOverflow = 1'b1;
                        end
                        functAddu: decoded.op = opAdd;
                        functSub: begin
                            decoded.op = opSub;
                            decoded.trapOnOverflow = 1'b1;
                        end
                        functSubu: decoded.op = opSub;
                        default: decoded.op = opNone;
                    endcase
                end
            end
            opcodeSpecial2: begin
                decoded.destination = instruction.r.c;
                if (shamtZero) begin
                    case (instruction.r.funct)
                        functClo: decoded.op = opClo;
                        functClz: decoded.op = opClz;
                        default: decoded.op = opNone;
                    endcase
                end
            end
            opcodeAddi: begin
                // I forms write register b
                decoded.op = opAdd;
                decoded.useImmediate = 1'b1;
                decoded.trapOnOverflow = 1'b1;
                decoded.destination = instruction.i.b;
            end
            opcodeAddiu: begin
                decoded.op = opAdd;
                decoded.useImmediate = 1'b1;
                decoded.destination = instruction.i.b;
            end
            default: decoded.op = opNone;
        endcase
    end

endmodule

`default_nettype wire

/* logic/addSubtractUnit.sv */
`default_nettype none

module addSubtractUnit
    import aluPkg::*;
(
    input decodedOp decoded,
    input dataWord gprA,
    input dataWord gprB,
    output dataWord arithResult,
    output logic arithOverflow
);

    // ---------------------------------------------------------------------
    // Operand select
    // ---------------------------------------------------------------------

    dataWord operandB;
    logic subtract;
    // Sign of b as it actually enters the sum
    logic effectiveSignB;

    assign operandB = decoded.useImmediate ? decoded.immediate : gprB;
    assign subtract = (decoded.op == opSub);
    assign effectiveSignB = operandB[dataWidth-1] ^ subtract;

    // ---------------------------------------------------------------------
    // Add / subtract
    // ---------------------------------------------------------------------

    assign arithResult = subtract ? (gprA - operandB) : (gprA + operandB);

    // Two's-complement overflow
    // Both inputs agree in sign but the result does not
    // Trap policy is applied later in write-back
    assign arithOverflow = (gprA[dataWidth-1] == effectiveSignB)
                         && (arithResult[dataWidth-1] != gprA[dataWidth-1]);

endmodule

`default_nettype wire

/* logic/leadingCountUnit.sv */
`default_nettype none

module leadingCountUnit
    import aluPkg::*;
(
    input decodedOp decoded,
    input dataWord gprA,
    output logic [countWidth-1:0] leadingCount
);

    // ---------------------------------------------------------------------
    // Operand conditioning
    // ---------------------------------------------------------------------

    // Leading ones become leading zeros once inverted,
    // so one zero counter serves both CLO and CLZ
    dataWord scanned;

    assign scanned = (decoded.op == opClo) ? ~gprA : gprA;

    // ---------------------------------------------------------------------
    // Priority scan from the MSB
    // ---------------------------------------------------------------------

    always_comb begin
        // No set bit at all gives the full width
        leadingCount = countWidth'(dataWidth);
        // Ascending loop, so the highest set bit is the last one to win
        for (int i = 0; i < dataWidth; i++) begin
            if (scanned[i]) begin
                leadingCount = countWidth'(dataWidth - 1 - i);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/writeBackStage.sv */
`default_nettype none

module writeBackStage
    import aluPkg::*;
(
    input logic Clock,
    input logic reset,
    input decodedOp decoded,
    input dataWord arithResult,
    input logic arithOverflow,
    input logic [countWidth-1:0] leadingCount,
    output writeBack result
);

    // ---------------------------------------------------------------------
    // Next record
    // ---------------------------------------------------------------------

    writeBack nextResult;
    logic isArith;
    // Overflow only matters for ADD, ADDI and SUB
    logic trapped;

    assign isArith = (decoded.op == opAdd) || (decoded.op == opSub);
    assign trapped = decoded.trapOnOverflow && arithOverflow;

    always_comb begin
        nextResult.destination = decoded.destination;

        // Count is zero-extended up to a full word
        if (isArith) begin
            nextResult.data = arithResult;
        end else begin
            nextResult.data = dataWord'(leadingCount);
        end

        // Trapping forms leave the destination untouched
        nextResult.writeEnable = (decoded.op != opNone) && !trapped;
        nextResult.overflow = trapped;

        // Zero flag follows the raw sum, counts never raise it
        nextResult.zero = isArith && (arithResult == '0);
    end

    // ---------------------------------------------------------------------
    // Output register
    // ---------------------------------------------------------------------

    // Single pipeline stage, result appears one edge after the inputs
    always_ff @(posedge Clock) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= nextResult;
        end
    end

endmodule

`default_nettype wire

/* logic/aluArithmetic.sv */
`default_nettype none

module aluArithmetic
    import aluPkg::*;
(
    input logic Clock,
    input logic reset,
    input instrWord instruction,
    input dataWord gprA,
    input dataWord gprB,
    output writeBack result
);

    // ---------------------------------------------------------------------
    // Internal nets
    // ---------------------------------------------------------------------

    decodedOp decoded;
    dataWord arithResult;
    logic arithOverflow;
    logic [countWidth-1:0] leadingCount;

    // ---------------------------------------------------------------------
    // Decode, execute, write-back
    // ---------------------------------------------------------------------

    instructionDecoder decoder (
        .instruction(instruction),
        .decoded(decoded)
    );

    // Both units see every instruction, write-back picks one
    addSubtractUnit adder (
        .decoded(decoded),
        .gprA(gprA),
        .gprB(gprB),
        .arithResult(arithResult),
        .arithOverflow(arithOverflow)
    );

    leadingCountUnit counter (
        .decoded(decoded),
        .gprA(gprA),
        .leadingCount(leadingCount)
    );

    // Only stage holding state
    writeBackStage writeBackReg (
        .Clock(Clock),
        .reset(reset),
        .decoded(decoded),
        .arithResult(arithResult),
        .arithOverflow(arithOverflow),
        .leadingCount(leadingCount),
        .result(result)
    );

endmodule

`default_nettype wire

/* dv/tbAluArithmetic.sv */
`default_nettype none

module tbAluArithmetic
    import aluPkg::*;
;

    // ---------------------------------------------------------------------
    // Run length and watchdog budget
    // ---------------------------------------------------------------------

    localparam int resetCycles = 5;
    // Reset checks plus the four tests and one flush per test
    localparam int issuedCount = resetCycles + 1 + 26 + 14 + 20 + 40 + 4;
    localparam int clockPeriod = 100;
    localparam int watchdogTime = 2 * (issuedCount + 20) * clockPeriod;

    logic Clock = 1'b0;
    logic reset;
    instrWord instruction;
    dataWord gprA;
    dataWord gprB;
    writeBack result;

    // Record expected one cycle after the last issued instruction
    writeBack pendingRecord;
    logic pendingValid;

    aluArithmetic dut (
        .Clock(Clock),
        .reset(reset),
        .instruction(instruction),
        .gprA(gprA),
        .gprB(gprB),
        .result(result)
    );

    always #(clockPeriod / 2) Clock = ~Clock;

    initial begin
        #(watchdogTime);
        $display("Watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    // ---------------------------------------------------------------------
    // Reference model of the write-back record
    // ---------------------------------------------------------------------

    function automatic writeBack modelRecord(input logic [31:0] word, input dataWord a,
                                             input dataWord b);
        writeBack expected;
        logic [5:0] opcode;
        logic [5:0] funct;
        logic [4:0] shamt;
        logic [15:0] imm;
        logic isAdd;
        logic isSub;
        logic countOnes;
        logic countZeros;
        logic traps;
        logic searching;
        dataWord operand;
        logic [32:0] wide;
        int count;
        opcode = word[31:26];
        shamt = word[10:6];
        funct = word[5:0];
        imm = word[15:0];
        {isAdd, isSub, countOnes, countZeros, traps} = '0;
        operand = b;
        expected = '0;
        if (opcode == opcodeSpecial && shamt == 5'd0) begin
            expected.destination = word[15:11];
            case (funct)
                functAdd: {isAdd, traps} = 2'b11;
                functAddu: isAdd = 1'b1;
                functSub: {isSub, traps} = 2'b11;
                functSubu: isSub = 1'b1;
                default: isAdd = 1'b0;
            endcase
        end else if (opcode == opcodeSpecial2 && shamt == 5'd0) begin
            expected.destination = word[15:11];
            countOnes = (funct == functClo);
            countZeros = (funct == functClz);
        end else if (opcode == opcodeAddi || opcode == opcodeAddiu) begin
            // I forms target register b with a sign-extended immediate
            expected.destination = word[20:16];
            isAdd = 1'b1;
            traps = (opcode == opcodeAddi);
            operand = {{16{imm[15]}}, imm};
        end
        if (isAdd || isSub) begin
            // 33-bit signed sum overflows when its top two bits differ
            if (isAdd) begin
                wide = {a[31], a} + {operand[31], operand};
            end else begin
                wide = {a[31], a} - {operand[31], operand};
            end
            expected.data = wide[31:0];
            expected.zero = (wide[31:0] == 32'd0);
            expected.overflow = traps && (wide[32] != wide[31]);
            expected.writeEnable = !expected.overflow;
        end else if (countOnes || countZeros) begin
            count = 0;
            searching = 1'b1;
            for (int i = 31; i >= 0; i--) begin
                if (searching && (a[i] == countOnes)) begin
                    count++;
                end else begin
                    searching = 1'b0;
                end
            end
            expected.data = count;
            expected.writeEnable = 1'b1;
        end
        return expected;
    endfunction

    // ---------------------------------------------------------------------
    // Stimulus and check helpers
    // ---------------------------------------------------------------------

    function automatic regIndex randomReg();
        logic [31:0] r;
        r = $urandom;
        return r[4:0];
    endfunction

    function automatic logic [31:0] rForm(input logic [5:0] opcode, input logic [5:0] funct,
                                          input logic [4:0] shamt);
        return {opcode, randomReg(), randomReg(), randomReg(), shamt, funct};
    endfunction

    function automatic logic [31:0] iForm(input logic [5:0] opcode, input logic [15:0] imm);
        return {opcode, randomReg(), randomReg(), imm};
    endfunction

    task automatic checkField(input string name, input logic [31:0] expectedValue,
                              input logic [31:0] actualValue);
        assert (actualValue === expectedValue) else begin
            $display("[FAIL] time %0t: %s expected %h got %h", $time, name, expectedValue,
                     actualValue);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // Destination and data only matter when the record writes
    task automatic checkRecord(input writeBack expected);
        checkField("result.writeEnable", 32'(expected.writeEnable), 32'(result.writeEnable));
        checkField("result.overflow", 32'(expected.overflow), 32'(result.overflow));
        checkField("result.zero", 32'(expected.zero), 32'(result.zero));
        if (expected.writeEnable) begin
            checkField("result.destination", 32'(expected.destination),
                       32'(result.destination));
            checkField("result.data", expected.data, result.data);
        end
    endtask

    // Check the previous instruction and drive the next one on the falling edge
    task automatic issue(input logic [31:0] word, input dataWord a, input dataWord b);
        @(negedge Clock);
        if (pendingValid) begin
            checkRecord(pendingRecord);
        end
        instruction = word;
        gprA = a;
        gprB = b;
        pendingRecord = modelRecord(word, a, b);
        pendingValid = 1'b1;
    endtask

    task automatic flush();
        @(negedge Clock);
        if (pendingValid) begin
            checkRecord(pendingRecord);
        end
        instruction = '0;
        gprA = '0;
        gprB = '0;
        pendingValid = 1'b0;
    endtask

    // ---------------------------------------------------------------------
    // Directed tests
    // ---------------------------------------------------------------------

    task automatic testReset();
        for (int cycle = 0; cycle < resetCycles; cycle++) begin
            @(negedge Clock);
            checkRecord('0);
            checkField("result.destination", 32'd0, 32'(result.destination));
            checkField("result.data", 32'd0, result.data);
        end
        reset = 1'b0;
        // First record after release comes from the all-zero word
        @(negedge Clock);
        checkRecord('0);
    endtask

    task automatic testNonTrapping();
        dataWord a;
        logic [31:0] imm;
        for (int i = 0; i < 8; i++) begin
            issue(rForm(opcodeSpecial, functAddu, 5'd0), $urandom, $urandom);
            issue(rForm(opcodeSpecial, functSubu, 5'd0), $urandom, $urandom);
            // Alternate the immediate sign
            imm = $urandom;
            imm[15] = i[0];
            issue(iForm(opcodeAddiu, imm[15:0]), $urandom, $urandom);
        end
        a = $urandom;
        issue(rForm(opcodeSpecial, functAddu, 5'd0), a, -a);
        issue(rForm(opcodeSpecial, functSubu, 5'd0), a, a);
        flush();
    endtask

    task automatic testTrapping();
        issue(rForm(opcodeSpecial, functAdd, 5'd0), 32'd1, 32'd2);
        issue(rForm(opcodeSpecial, functAdd, 5'd0), 32'h7fff_ffff, 32'd1);
        issue(rForm(opcodeSpecial, functAdd, 5'd0), 32'h8000_0000, 32'hffff_ffff);
        // Raw sum wraps to zero and overflows
        issue(rForm(opcodeSpecial, functAdd, 5'd0), 32'h8000_0000, 32'h8000_0000);
        issue(rForm(opcodeSpecial, functAdd, 5'd0), 32'hffff_fffb, 32'd3);
        issue(rForm(opcodeSpecial, functSub, 5'd0), 32'h8000_0000, 32'd1);
        issue(rForm(opcodeSpecial, functSub, 5'd0), 32'h7fff_ffff, 32'hffff_ffff);
        issue(rForm(opcodeSpecial, functSub, 5'd0), 32'd5, 32'd7);
        issue(rForm(opcodeSpecial, functSub, 5'd0), 32'd0, 32'h8000_0000);
        issue(iForm(opcodeAddi, 16'h0100), 32'h7fff_ff00, $urandom);
        issue(iForm(opcodeAddi, 16'hffff), 32'h8000_0000, $urandom);
        issue(iForm(opcodeAddi, 16'hfff0), 32'd10, $urandom);
        // Unsigned forms with the same operands just wrap
        issue(rForm(opcodeSpecial, functAddu, 5'd0), 32'h7fff_ffff, 32'd1);
        issue(rForm(opcodeSpecial, functSubu, 5'd0), 32'h8000_0000, 32'd1);
        flush();
    endtask

    task automatic testCounts();
        int positions[3] = '{0, 13, 31};
        dataWord value;
        int shift;
        issue(rForm(opcodeSpecial2, functClo, 5'd0), 32'hffff_ffff, $urandom);
        issue(rForm(opcodeSpecial2, functClz, 5'd0), 32'hffff_ffff, $urandom);
        issue(rForm(opcodeSpecial2, functClo, 5'd0), 32'd0, $urandom);
        issue(rForm(opcodeSpecial2, functClz, 5'd0), 32'd0, $urandom);
        for (int k = 0; k < 3; k++) begin
            value = 32'd1 << positions[k];
            issue(rForm(opcodeSpecial2, functClz, 5'd0), value, $urandom);
            issue(rForm(opcodeSpecial2, functClo, 5'd0), ~value, $urandom);
        end
        // Random shift spreads the counts over the whole range
        for (int k = 0; k < 5; k++) begin
            value = $urandom;
            shift = $urandom % 32;
            value = value >> shift;
            issue(rForm(opcodeSpecial2, functClz, 5'd0), value, $urandom);
            issue(rForm(opcodeSpecial2, functClo, 5'd0), ~value, $urandom);
        end
        flush();
    endtask

    task automatic testStream();
        int kind;
        logic [31:0] word;
        for (int i = 0; i < 40; i++) begin
            // First two are the all-zero word and a nonzero shamt
            kind = (i < 2) ? 8 + i : $urandom % 11;
            case (kind)
                0: word = rForm(opcodeSpecial, functAdd, 5'd0);
                1: word = rForm(opcodeSpecial, functAddu, 5'd0);
                2: word = rForm(opcodeSpecial, functSub, 5'd0);
                3: word = rForm(opcodeSpecial, functSubu, 5'd0);
                4: word = iForm(opcodeAddi, randomReg() * 16'd1999);
                5: word = iForm(opcodeAddiu, randomReg() * 16'd2047);
                6: word = rForm(opcodeSpecial2, functClo, 5'd0);
                7: word = rForm(opcodeSpecial2, functClz, 5'd0);
                8: word = 32'd0;
                9: word = rForm(opcodeSpecial, functAdd, randomReg() | 5'd1);
                default: word = $urandom;
            endcase
            issue(word, $urandom, $urandom);
        end
        flush();
    endtask

    // ---------------------------------------------------------------------
    // Main sequence
    // ---------------------------------------------------------------------

    initial begin
        void'($urandom(32'h11f6_af4b));
        reset = 1'b1;
        instruction = '0;
        gprA = '0;
        gprB = '0;
        pendingRecord = '0;
        pendingValid = 1'b0;
        testReset();
        testNonTrapping();
        testTrapping();
        testCounts();
        testStream();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
logic/aluPkg.sv
logic/instructionDecoder.sv
logic/addSubtractUnit.sv
logic/leadingCountUnit.sv
logic/writeBackStage.sv
logic/aluArithmetic.sv
dv/tbAluArithmetic.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ALU arithmetic testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module tbAluArithmetic \
    -Mdir obj_dir \
    -o simAluArithmetic

# The simulator exits nonzero on a fatal check, the log decides the result
./obj_dir/simAluArithmetic > sim.log 2>&1 || true
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
